// ==== csr_config.svh ====
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Machine word and CSR address widths
`define XLEN                32
`define CSR_ADDR_W          12

// Machine trap setup
`define CSR_MSTATUS         12'h300
`define CSR_MIE             12'h304
`define CSR_MTVEC           12'h305

// Machine trap handling
`define CSR_MSCRATCH        12'h340
`define CSR_MEPC            12'h341
`define CSR_MCAUSE          12'h342

// User-visible timer, read only
`define CSR_TIME            12'hc01
`define CSR_TIMEH           12'hc81

// mstatus fields that are kept
`define MSTATUS_MIE_BIT     3
`define MSTATUS_MPIE_BIT    7
`define MSTATUS_MPP_LSB     11

// mie.MTIE, also the timer bit position in mip
`define MIE_MTIE_BIT        7

// Interrupt flag in the top bit, code 7 below it
`define CAUSE_M_TIMER       32'h8000_0007

// ECALL cause is this base plus the mode it came from
`define CAUSE_ECALL_BASE    8

`endif

// ==== csr_pkg.sv ====
`default_nettype none

`include "csr_config.svh"

package csr_pkg;

    // One CSR value or one pc
    typedef logic [`XLEN-1:0] csr_data_t;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // mtime and mtimecmp are always 64 bits, also on RV32
    typedef logic [63:0] time_t;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    // Encoding follows mstatus.MPP
    typedef enum logic [1:0] {
        MODE_U = 2'b00,
        MODE_M = 2'b11
    } priv_mode_e;

    // Command port handshake FSM
    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        DONE
    } port_state_e;

endpackage

`default_nettype wire

// ==== csr_cmd_port.sv ====
`default_nettype none

`include "csr_config.svh"

module csr_cmd_port (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    req,
    input  wire csr_pkg::csr_cmd_e cmd,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire csr_pkg::csr_data_t wdata,
    input  wire csr_pkg::csr_data_t exec_rdata,
    input  wire                    trap_busy,
    output logic                   ack,
    output csr_pkg::csr_data_t     rdata,
    output logic                   exec,
    output csr_pkg::csr_cmd_e      exec_cmd,
    output csr_pkg::csr_addr_t     exec_addr,
    output csr_pkg::csr_data_t     exec_wdata
);

    csr_pkg::port_state_e state;

    // A trap taken this cycle pushes the command back by one cycle or more
    assign exec = (state == csr_pkg::EXEC) && !trap_busy;

    // ack stays up from the end of the exec cycle until req drops
    assign ack = (state == csr_pkg::DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= csr_pkg::IDLE;
        end else begin
            case (state)
                csr_pkg::IDLE: begin
                    if (req) begin
                        state <= csr_pkg::EXEC;
                    end
                end
                csr_pkg::EXEC: begin
                    if (!trap_busy) begin
                        state <= csr_pkg::DONE;
                    end
                end
                csr_pkg::DONE: begin
                    if (!req) begin
                        state <= csr_pkg::IDLE;
                    end
                end
                default: state <= csr_pkg::IDLE;
            endcase
        end
    end

    // Request fields, held for the whole command
    always_ff @(posedge clk) begin
        if (state == csr_pkg::IDLE && req) begin
            exec_cmd   <= cmd;
            exec_addr  <= addr;
            exec_wdata <= wdata;
        end
    end

    // Old register value, valid while ack is high
    always_ff @(posedge clk) begin
        if (exec) begin
            rdata <= exec_rdata;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req);

    // The requester keeps req up until it sees ack
    a_req_held_in_exec: assert property (@(posedge clk) disable iff (!rst_n)
        (state == csr_pkg::EXEC) |-> req);

endmodule

`default_nettype wire

// ==== csr_file.sv ====
`default_nettype none

`include "csr_config.svh"

module csr_file (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        exec,
    input  wire csr_pkg::csr_cmd_e     exec_cmd,
    input  wire csr_pkg::csr_addr_t    exec_addr,
    input  wire csr_pkg::csr_data_t    exec_wdata,
    input  wire csr_pkg::time_t        mtime,
    input  wire csr_pkg::priv_mode_e   priv_mode,
    input  wire                        trap_enter,
    input  wire csr_pkg::csr_data_t    enter_cause,
    input  wire csr_pkg::csr_data_t    enter_epc,
    input  wire                        trap_return,
    output csr_pkg::csr_data_t         exec_rdata,
    output logic                       mstatus_mie,
    output logic                       mstatus_mpie,
    output csr_pkg::priv_mode_e        mstatus_mpp,
    output logic                       mie_mtie,
    output csr_pkg::csr_data_t         mtvec,
    output csr_pkg::csr_data_t         mepc
);

    csr_pkg::csr_data_t mscratch;
    csr_pkg::csr_data_t mcause;
    csr_pkg::csr_data_t wr_val;
    logic               wr_en;

    // Read mux, unimplemented fields and addresses give 0
    always_comb begin
        exec_rdata = '0;
        case (exec_addr)
            `CSR_MSTATUS: begin
                exec_rdata[`MSTATUS_MIE_BIT]       = mstatus_mie;
                exec_rdata[`MSTATUS_MPIE_BIT]      = mstatus_mpie;
                exec_rdata[`MSTATUS_MPP_LSB +: 2]  = mstatus_mpp;
            end
            `CSR_MIE:      exec_rdata[`MIE_MTIE_BIT] = mie_mtie;
            `CSR_MTVEC:    exec_rdata = mtvec;
            `CSR_MSCRATCH: exec_rdata = mscratch;
            `CSR_MEPC:     exec_rdata = mepc;
            `CSR_MCAUSE:   exec_rdata = mcause;
            `CSR_TIME:     exec_rdata = mtime[`XLEN-1:0];
            `CSR_TIMEH:    exec_rdata = mtime[63:`XLEN];
            default:       exec_rdata = '0;
        endcase
    end

    // New value from the old one, ECALL and MRET write nothing here
    always_comb begin
        wr_en  = 1'b0;
        wr_val = exec_rdata;
        case (exec_cmd)
            csr_pkg::CMD_W: begin
                wr_en  = exec;
                wr_val = exec_wdata;
            end
            csr_pkg::CMD_S: begin
                wr_en  = exec;
                wr_val = exec_rdata | exec_wdata;
            end
            csr_pkg::CMD_C: begin
                wr_en  = exec;
                wr_val = exec_rdata & ~exec_wdata;
            end
            default: wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= csr_pkg::MODE_M;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else if (trap_enter) begin
            // Stack the interrupt enable and remember where we came from
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= priv_mode;
            mepc         <= enter_epc;
            mcause       <= enter_cause;
        end else if (trap_return) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= csr_pkg::MODE_U;
        end else if (wr_en) begin
            case (exec_addr)
                `CSR_MSTATUS: begin
                    mstatus_mie  <= wr_val[`MSTATUS_MIE_BIT];
                    mstatus_mpie <= wr_val[`MSTATUS_MPIE_BIT];
                    // Only M and U exist, any other MPP value lands in U
                    mstatus_mpp  <= (wr_val[`MSTATUS_MPP_LSB +: 2] == 2'b11) ?
                                    csr_pkg::MODE_M : csr_pkg::MODE_U;
                end
                `CSR_MIE:      mie_mtie <= wr_val[`MIE_MTIE_BIT];
                `CSR_MTVEC:    mtvec    <= wr_val;
                `CSR_MSCRATCH: mscratch <= wr_val;
                `CSR_MEPC:     mepc     <= wr_val;
                `CSR_MCAUSE:   mcause   <= wr_val;
                // time, timeh and unknown addresses drop the write
                default: ;
            endcase
        end
    end

    a_enter_return_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_enter && trap_return));

endmodule

`default_nettype wire

// ==== trap_ctrl.sv ====
`default_nettype none

`include "csr_config.svh"

module trap_ctrl (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        exec,
    input  wire csr_pkg::csr_cmd_e     exec_cmd,
    input  wire csr_pkg::csr_data_t    pc,
    input  wire csr_pkg::time_t        mtime,
    input  wire csr_pkg::time_t        mtimecmp,
    input  wire                        interrupt_ready,
    input  wire                        mstatus_mie,
    input  wire csr_pkg::priv_mode_e   mstatus_mpp,
    input  wire                        mie_mtie,
    input  wire csr_pkg::csr_data_t    mtvec,
    input  wire csr_pkg::csr_data_t    mepc,
    output logic                       trap_busy,
    output logic                       trap_enter,
    output csr_pkg::csr_data_t         enter_cause,
    output csr_pkg::csr_data_t         enter_epc,
    output logic                       trap_return,
    output logic                       redirect,
    output csr_pkg::csr_data_t         trap_vector,
    output csr_pkg::priv_mode_e        priv_mode
);

    logic timer_pending;
    logic take_irq;
    logic take_ecall;
    logic take_mret;

    // U mode is always interruptible, M mode only with MIE
    assign timer_pending = (mtime >= mtimecmp) && mie_mtie &&
                           ((priv_mode == csr_pkg::MODE_U) || mstatus_mie);

    // Nothing is taken while the previous redirect is still out
    assign take_irq   = timer_pending && interrupt_ready && !redirect;
    assign trap_busy  = take_irq || redirect;

    assign take_ecall = exec && (exec_cmd == csr_pkg::CMD_ECALL);
    assign take_mret  = exec && (exec_cmd == csr_pkg::CMD_MRET);

    assign trap_enter  = take_irq || take_ecall;
    assign trap_return = take_mret;
    assign enter_epc   = pc;

    // ECALL from U gives 8, from M gives 11
    assign enter_cause = take_irq ? `CAUSE_M_TIMER :
                         csr_pkg::csr_data_t'(`CAUSE_ECALL_BASE) +
                         csr_pkg::csr_data_t'(priv_mode);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect  <= 1'b0;
            priv_mode <= csr_pkg::MODE_M;
        end else begin
            redirect <= trap_enter || take_mret;
            if (trap_enter) begin
                priv_mode <= csr_pkg::MODE_M;
            end else if (take_mret) begin
                priv_mode <= mstatus_mpp;
            end
        end
    end

    // Target only matters while redirect is high
    always_ff @(posedge clk) begin
        if (trap_enter) begin
            trap_vector <= mtvec;
        end else if (take_mret) begin
            trap_vector <= mepc;
        end
    end

    a_redirect_single: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect);

    // Trap entry lands in M mode with interrupts masked by the register file
    a_enter_to_m: assert property (@(posedge clk) disable iff (!rst_n)
        trap_enter |=> (priv_mode == csr_pkg::MODE_M) && !mstatus_mie);

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`default_nettype none

module csr_unit (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        req,
    input  wire csr_pkg::csr_cmd_e     cmd,
    input  wire csr_pkg::csr_addr_t    addr,
    input  wire csr_pkg::csr_data_t    wdata,
    output wire                        ack,
    output wire csr_pkg::csr_data_t    rdata,
    input  wire csr_pkg::time_t        mtime,
    input  wire csr_pkg::time_t        mtimecmp,
    input  wire                        interrupt_ready,
    input  wire csr_pkg::csr_data_t    pc,
    output wire                        redirect,
    output wire csr_pkg::csr_data_t    trap_vector,
    output wire csr_pkg::priv_mode_e   priv_mode
);

    // Command port to register file and trap control
    wire                      exec;
    wire csr_pkg::csr_cmd_e   exec_cmd;
    wire csr_pkg::csr_addr_t  exec_addr;
    wire csr_pkg::csr_data_t  exec_wdata;
    wire csr_pkg::csr_data_t  exec_rdata;
    wire                      trap_busy;

    // Trap control and register file
    wire                      trap_enter;
    wire csr_pkg::csr_data_t  enter_cause;
    wire csr_pkg::csr_data_t  enter_epc;
    wire                      trap_return;
    wire                      mstatus_mie;
    wire csr_pkg::priv_mode_e mstatus_mpp;
    wire                      mie_mtie;
    wire csr_pkg::csr_data_t  mtvec;
    wire csr_pkg::csr_data_t  mepc;

    csr_cmd_port i_cmd_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .cmd        (cmd),
        .addr       (addr),
        .wdata      (wdata),
        .exec_rdata (exec_rdata),
        .trap_busy  (trap_busy),
        .ack        (ack),
        .rdata      (rdata),
        .exec       (exec),
        .exec_cmd   (exec_cmd),
        .exec_addr  (exec_addr),
        .exec_wdata (exec_wdata)
    );

    csr_file i_csr_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .exec         (exec),
        .exec_cmd     (exec_cmd),
        .exec_addr    (exec_addr),
        .exec_wdata   (exec_wdata),
        .mtime        (mtime),
        .priv_mode    (priv_mode),
        .trap_enter   (trap_enter),
        .enter_cause  (enter_cause),
        .enter_epc    (enter_epc),
        .trap_return  (trap_return),
        .exec_rdata   (exec_rdata),
        .mstatus_mie  (mstatus_mie),
        .mstatus_mpie (),
        .mstatus_mpp  (mstatus_mpp),
        .mie_mtie     (mie_mtie),
        .mtvec        (mtvec),
        .mepc         (mepc)
    );

    trap_ctrl i_trap_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .exec            (exec),
        .exec_cmd        (exec_cmd),
        .pc              (pc),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .interrupt_ready (interrupt_ready),
        .mstatus_mie     (mstatus_mie),
        .mstatus_mpp     (mstatus_mpp),
        .mie_mtie        (mie_mtie),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .trap_busy       (trap_busy),
        .trap_enter      (trap_enter),
        .enter_cause     (enter_cause),
        .enter_epc       (enter_epc),
        .trap_return     (trap_return),
        .redirect        (redirect),
        .trap_vector     (trap_vector),
        .priv_mode       (priv_mode)
    );

endmodule

`default_nettype wire

// ==== tb_csr_unit.sv ====
`default_nettype none

`include "csr_config.svh"

module tb_csr_unit;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 50;
    localparam csr_pkg::csr_data_t mtie_mask = csr_pkg::csr_data_t'(1) << `MIE_MTIE_BIT;
    localparam csr_pkg::csr_data_t mie_mask = csr_pkg::csr_data_t'(1) << `MSTATUS_MIE_BIT;
    localparam csr_pkg::csr_data_t mpp_mask = csr_pkg::csr_data_t'(3) << `MSTATUS_MPP_LSB;
    localparam csr_pkg::csr_addr_t unmapped_addr = 12'h7c0;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  req;
    csr_pkg::csr_cmd_e     cmd;
    csr_pkg::csr_addr_t    addr;
    csr_pkg::csr_data_t    wdata;
    logic                  ack;
    csr_pkg::csr_data_t    rdata;
    csr_pkg::time_t        mtime;
    csr_pkg::time_t        mtimecmp;
    logic                  interrupt_ready;
    csr_pkg::csr_data_t    pc;
    logic                  redirect;
    csr_pkg::csr_data_t    trap_vector;
    csr_pkg::priv_mode_e   priv_mode;

    integer                seed;
    logic                  cmd_redirect;
    csr_pkg::csr_data_t    cmd_vector;

    // Reference model of the CSRs and the mode
    csr_pkg::csr_data_t    m_mscratch;
    csr_pkg::csr_data_t    m_mtvec;
    csr_pkg::csr_data_t    m_mepc;
    csr_pkg::csr_data_t    m_mcause;
    logic                  m_mie;
    logic                  m_mpie;
    logic                  m_mtie;
    csr_pkg::priv_mode_e   m_mpp;
    csr_pkg::priv_mode_e   m_mode;

    always #50 clk = ~clk;

    csr_unit i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .cmd             (cmd),
        .addr            (addr),
        .wdata           (wdata),
        .ack             (ack),
        .rdata           (rdata),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .interrupt_ready (interrupt_ready),
        .pc              (pc),
        .redirect        (redirect),
        .trap_vector     (trap_vector),
        .priv_mode       (priv_mode)
    );

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_value(input csr_pkg::csr_data_t got, input csr_pkg::csr_data_t exp,
                               input string what);
        assert (got === exp)
        else report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_mode(input csr_pkg::priv_mode_e exp, input string what);
        assert (priv_mode === exp)
        else report_mismatch($sformatf("%s: priv_mode %0d, expected %0d", what, priv_mode, exp));
    endtask

    // mstatus as the model expects it to read
    function automatic csr_pkg::csr_data_t mstatus_value();
        csr_pkg::csr_data_t v;
        v = '0;
        v[`MSTATUS_MIE_BIT] = m_mie;
        v[`MSTATUS_MPIE_BIT] = m_mpie;
        v[`MSTATUS_MPP_LSB +: 2] = m_mpp;
        return v;
    endfunction

    // One full four-phase handshake, req held hold extra cycles after ack
    task automatic run_cmd(input csr_pkg::csr_cmd_e c, input csr_pkg::csr_addr_t a,
                           input csr_pkg::csr_data_t d, input int hold,
                           output csr_pkg::csr_data_t old);
        int n;
        @(posedge clk);
        req   <= 1'b1;
        cmd   <= c;
        addr  <= a;
        wdata <= d;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack && n < timeout_cycles);
        if (!ack) begin
            report_timeout("ack timeout");
        end
        old          = rdata;
        cmd_redirect = redirect;
        cmd_vector   = trap_vector;
        repeat (hold) @(negedge clk);
        // A second execution would overwrite the captured old value
        if (hold > 0) begin
            check_value(rdata, old, "rdata held through ack");
        end
        @(posedge clk);
        req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (ack && n < timeout_cycles);
        if (ack) begin
            report_timeout("ack timeout");
        end
    endtask

    task automatic expect_csr(input csr_pkg::csr_addr_t a, input csr_pkg::csr_data_t exp,
                              input string what);
        csr_pkg::csr_data_t val;
        run_cmd(csr_pkg::CMD_S, a, '0, 0, val);
        check_value(val, exp, what);
    endtask

    task automatic wait_redirect();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!redirect && n < timeout_cycles);
        if (!redirect) begin
            report_timeout("redirect timeout");
        end
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            assert (!redirect)
            else report_mismatch($sformatf("unexpected redirect, %s", what));
        end
    endtask

    // Watches ack against req for the whole run
    task automatic monitor_handshake();
        logic ack_q;
        ack_q = 1'b0;
        forever begin
            @(negedge clk);
            assert (!ack || ack_q || req)
            else report_mismatch("ack rose while req low");
            assert (ack || !ack_q || !req)
            else report_mismatch("ack fell while req high");
            ack_q = ack;
        end
    endtask

    initial begin
        csr_pkg::csr_data_t old;
        csr_pkg::csr_data_t val_w;
        csr_pkg::csr_data_t val_s;
        csr_pkg::csr_data_t val_c;
        csr_pkg::csr_data_t new_pc;
        csr_pkg::time_t     now;

        seed = 32'h7e73_9cf9;
        rst_n           <= 1'b0;
        req             <= 1'b0;
        cmd             <= csr_pkg::CMD_NONE;
        addr            <= '0;
        wdata           <= '0;
        mtime           <= '0;
        mtimecmp        <= '1;
        interrupt_ready <= 1'b0;
        pc              <= '0;
        m_mscratch = '0;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_mtie     = 1'b0;
        m_mpp      = csr_pkg::MODE_M;
        m_mode     = csr_pkg::MODE_M;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (ack === 1'b0 && redirect === 1'b0)
        else report_mismatch("ack or redirect high after reset");
        check_mode(csr_pkg::MODE_M, "after reset");
        fork
            monitor_handshake();
        join_none

        // Read-modify-write on mscratch
        val_w = $random(seed);
        val_s = $random(seed);
        val_c = $random(seed);
        run_cmd(csr_pkg::CMD_W, `CSR_MSCRATCH, val_w, 0, old);
        check_value(old, m_mscratch, "mscratch old value on W");
        m_mscratch = val_w;
        run_cmd(csr_pkg::CMD_S, `CSR_MSCRATCH, val_s, 0, old);
        check_value(old, m_mscratch, "mscratch old value on S");
        m_mscratch = m_mscratch | val_s;
        run_cmd(csr_pkg::CMD_C, `CSR_MSCRATCH, val_c, 0, old);
        check_value(old, m_mscratch, "mscratch old value on C");
        m_mscratch = m_mscratch & ~val_c;
        expect_csr(`CSR_MSCRATCH, (val_w | val_s) & ~val_c, "mscratch after W, S, C");

        // time and timeh ignore writes, unknown addresses read zero
        now = {$random(seed), $random(seed)};
        @(posedge clk);
        mtime <= now;
        expect_csr(`CSR_TIME, now[31:0], "time");
        expect_csr(`CSR_TIMEH, now[63:32], "timeh");
        run_cmd(csr_pkg::CMD_W, `CSR_TIME, $random(seed), 0, old);
        run_cmd(csr_pkg::CMD_W, `CSR_TIMEH, $random(seed), 0, old);
        expect_csr(`CSR_TIME, now[31:0], "time after write");
        expect_csr(`CSR_TIMEH, now[63:32], "timeh after write");
        run_cmd(csr_pkg::CMD_W, unmapped_addr, $random(seed), 0, old);
        check_value(old, '0, "unmapped address");
        expect_csr(unmapped_addr, '0, "unmapped address after write");

        // Timer interrupt taken from M mode with MIE set
        m_mtvec = $random(seed) & ~32'h3;
        new_pc  = $random(seed) & ~32'h3;
        run_cmd(csr_pkg::CMD_W, `CSR_MTVEC, m_mtvec, 0, old);
        run_cmd(csr_pkg::CMD_S, `CSR_MIE, mtie_mask, 0, old);
        m_mtie = 1'b1;
        run_cmd(csr_pkg::CMD_S, `CSR_MSTATUS, mie_mask, 0, old);
        m_mie = 1'b1;
        @(posedge clk);
        pc              <= new_pc;
        mtimecmp        <= now;
        interrupt_ready <= 1'b1;
        wait_redirect();
        check_value(trap_vector, m_mtvec, "trap_vector on timer interrupt");
        m_mpie   = m_mie;
        m_mie    = 1'b0;
        m_mpp    = m_mode;
        m_mepc   = new_pc;
        m_mcause = `CAUSE_M_TIMER;
        m_mode   = csr_pkg::MODE_M;
        check_mode(m_mode, "after timer interrupt");
        @(posedge clk);
        interrupt_ready <= 1'b0;
        expect_csr(`CSR_MCAUSE, m_mcause, "mcause after timer interrupt");
        expect_csr(`CSR_MEPC, m_mepc, "mepc after timer interrupt");
        expect_csr(`CSR_MSTATUS, mstatus_value(), "mstatus after timer interrupt");

        // MRET into U mode
        run_cmd(csr_pkg::CMD_C, `CSR_MSTATUS, mpp_mask, 0, old);
        check_value(old, mstatus_value(), "mstatus old value on C");
        m_mpp = csr_pkg::MODE_U;
        m_mepc = $random(seed) & ~32'h3;
        run_cmd(csr_pkg::CMD_W, `CSR_MEPC, m_mepc, 0, old);
        run_cmd(csr_pkg::CMD_MRET, '0, '0, 0, old);
        assert (cmd_redirect === 1'b1)
        else report_mismatch("no redirect on MRET");
        check_value(cmd_vector, m_mepc, "MRET target");
        m_mie  = m_mpie;
        m_mpie = 1'b1;
        m_mode = m_mpp;
        m_mpp  = csr_pkg::MODE_U;
        check_mode(csr_pkg::MODE_U, "after MRET");
        expect_csr(`CSR_MSTATUS, mstatus_value(), "mstatus after MRET");

        // ECALL from U mode back to M
        new_pc = $random(seed) & ~32'h3;
        @(posedge clk);
        pc <= new_pc;
        run_cmd(csr_pkg::CMD_ECALL, '0, '0, 0, old);
        assert (cmd_redirect === 1'b1)
        else report_mismatch("no redirect on ECALL");
        check_value(cmd_vector, m_mtvec, "ECALL target");
        m_mpie   = m_mie;
        m_mie    = 1'b0;
        m_mpp    = m_mode;
        m_mepc   = new_pc;
        m_mcause = csr_pkg::csr_data_t'(`CAUSE_ECALL_BASE);
        m_mode   = csr_pkg::MODE_M;
        check_mode(csr_pkg::MODE_M, "after ECALL");
        expect_csr(`CSR_MCAUSE, m_mcause, "mcause after ECALL");
        expect_csr(`CSR_MEPC, m_mepc, "mepc after ECALL");
        expect_csr(`CSR_MSTATUS, mstatus_value(), "mstatus after ECALL");

        // Masking, first M mode with MIE clear, then MTIE clear
        @(posedge clk);
        interrupt_ready <= 1'b1;
        expect_quiet(40, "M mode with MIE clear");
        @(posedge clk);
        interrupt_ready <= 1'b0;
        run_cmd(csr_pkg::CMD_C, `CSR_MIE, mtie_mask, 0, old);
        check_value(old, csr_pkg::csr_data_t'(m_mtie) << `MIE_MTIE_BIT, "mie old value on C");
        m_mtie = 1'b0;
        run_cmd(csr_pkg::CMD_S, `CSR_MSTATUS, mie_mask, 0, old);
        m_mie = 1'b1;
        @(posedge clk);
        interrupt_ready <= 1'b1;
        expect_quiet(40, "MTIE clear");
        @(posedge clk);
        interrupt_ready <= 1'b0;

        // One execution per handshake even with req held long after ack
        run_cmd(csr_pkg::CMD_W, `CSR_MSCRATCH, '0, 0, old);
        m_mscratch = '0;
        run_cmd(csr_pkg::CMD_S, `CSR_MSCRATCH, 32'h1, 6, old);
        check_value(old, m_mscratch, "mscratch old value on held S");
        m_mscratch = m_mscratch | 32'h1;
        expect_csr(`CSR_MSCRATCH, m_mscratch, "mscratch after one S of 1");

        repeat (2) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
csr_pkg.sv
csr_cmd_port.sv
csr_file.sv
trap_ctrl.sv
csr_unit.sv
tb_csr_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module tb_csr_unit

# The search for the pass line decides the result
out=$(./obj_dir/Vtb_csr_unit 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors"
